// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int OPCODE_W   = 6;
  localparam int WORD_W     = 32;
  localparam int GREG_COUNT = 16;
  localparam int PREG_COUNT = 4;

  typedef logic [$clog2(GREG_COUNT)-1:0] greg_id_t;
  typedef logic [$clog2(PREG_COUNT)-1:0] preg_id_t;
  typedef logic [WORD_W-1:0]             word_t;

  localparam int SET_BIT  = 31; // guard enable
  localparam int PID_MSB  = 30;
  localparam int PID_LSB  = 29;
  localparam int OPC_MSB  = 28;
  localparam int OPC_LSB  = 23;
  localparam int Z_MSB    = 22;
  localparam int Z_LSB    = 19;
  localparam int Y_MSB    = 18;
  localparam int Y_LSB    = 15;
  localparam int XALT_MSB = 14; // overlaps the 15-bit immediate
  localparam int XALT_LSB = 11;
  localparam int IMM_MSB  = 22;
  localparam int IMM_LSB  = 0;
  localparam int IMM_W    = IMM_MSB - IMM_LSB + 1;

  typedef enum logic [OPCODE_W-1:0] {
    OP_NEG    = 6'h05,
    OP_NOT    = 6'h06,
    OP_AND    = 6'h07,
    OP_OR     = 6'h08,
    OP_XOR    = 6'h09,
    OP_ADD    = 6'h0a,
    OP_SUB    = 6'h0b,
    OP_MUL    = 6'h0c,
    OP_DIV    = 6'h0d,
    OP_MOD    = 6'h0e,
    OP_SHL    = 6'h0f,
    OP_SHR    = 6'h10,
    OP_ANDI   = 6'h11,
    OP_ORI    = 6'h12,
    OP_XORI   = 6'h13,
    OP_ADDI   = 6'h14,
    OP_SUBI   = 6'h15,
    OP_MULI   = 6'h16,
    OP_DIVI   = 6'h17,
    OP_MODI   = 6'h18,
    OP_SHLI   = 6'h19,
    OP_SHRI   = 6'h1a,
    OP_JALI   = 6'h1b,
    OP_JALR   = 6'h1c,
    OP_JMPI   = 6'h1d,
    OP_JMPR   = 6'h1e,
    OP_LD     = 6'h23,
    OP_ST     = 6'h24,
    OP_LDI    = 6'h25,
    OP_RTOP   = 6'h26,
    OP_ANDP   = 6'h27,
    OP_ORP    = 6'h28,
    OP_XORP   = 6'h29,
    OP_NOTP   = 6'h2a,
    OP_ISNEG  = 6'h2b,
    OP_ISZERO = 6'h2c
  } opcode_e;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  import isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_NONE = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_MUL  = 4'd3,
    ALU_DIV  = 4'd4,
    ALU_MOD  = 4'd5,
    ALU_SHL  = 4'd6,
    ALU_SHR  = 4'd7,
    ALU_AND  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_XOR  = 4'd10,
    ALU_NEG  = 4'd11,
    ALU_NOT  = 4'd12,
    ALU_PASS = 4'd13, // ldi
    ALU_LINK = 4'd14  // return address for jal
  } alu_op_e;

  // same field as seen by the predicate unit
  localparam alu_op_e PALU_AND    = ALU_ADD;
  localparam alu_op_e PALU_OR     = ALU_SUB;
  localparam alu_op_e PALU_XOR    = ALU_MUL;
  localparam alu_op_e PALU_NOT    = ALU_DIV;
  localparam alu_op_e PALU_RTOP   = ALU_MOD;
  localparam alu_op_e PALU_ISNEG  = ALU_SHL;
  localparam alu_op_e PALU_ISZERO = ALU_SHR;

  typedef enum logic [1:0] {
    EXT_NONE = 2'b00,
    EXT_S15  = 2'b01,
    EXT_S23  = 2'b10,
    EXT_S19  = 2'b11
  } ext_sel_e;

  typedef struct packed {
    logic    link;
    logic    src2_sel; // 1 selects the immediate
    alu_op_e alu_op;
    logic    pf_or_i;  // 1 integer result, 0 predicate result
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_w;
    logic mem_r;
  } mem_ctrl_t;

  typedef struct packed {
    logic rw_f;
    logic rw_r;
    logic rw_p;
    logic reg_mem;
  } wb_ctrl_t;

  typedef struct packed {
    logic reg_or_imm; // 1 for immediate target
    logic is_jump;
  } jmp_ctrl_t;

  typedef struct packed {
    logic has_rx;
    logic has_ry;
  } opc_use_t;

  typedef struct packed {
    opc_use_t  opc_use;
    wb_ctrl_t  wb;
    mem_ctrl_t mem;
    ex_ctrl_t  ex;
    jmp_ctrl_t jmp;
    ext_sel_e  ext_sel;
    logic      reg_id_sel;
  } ctrl_word_t;

  typedef struct packed {
    opc_use_t  opc_use;
    wb_ctrl_t  wb;
    mem_ctrl_t mem;
    ex_ctrl_t  ex;
    jmp_ctrl_t jmp;
  } stage_ctrl_t;

  typedef struct packed {
    logic     en;
    greg_id_t id;
    word_t    value;
  } greg_wr_t;

  typedef struct packed {
    logic     en;
    preg_id_t id;
    logic     value;
  } preg_wr_t;

  typedef struct packed {
    word_t    rx;
    word_t    ry;
    logic     px;
    logic     py;
    greg_id_t x_id;
    greg_id_t y_id;
    greg_id_t z_id;
    word_t    imm;
    word_t    jmp_target;
    logic     pval;
  } operands_t;

  function automatic logic [GREG_COUNT*WORD_W-1:0] greg_index_image();
    logic [GREG_COUNT*WORD_W-1:0] img;
    for (int i = 0; i < GREG_COUNT; i++)
      img[i*WORD_W +: WORD_W] = WORD_W'(i);
    return img;
  endfunction

  localparam logic [GREG_COUNT*WORD_W-1:0] GREG_RESET_IMAGE = greg_index_image();
  localparam logic [PREG_COUNT-1:0]        PREG_RESET_IMAGE = 4'b0011; // p0 p1 true

endpackage

`default_nettype wire

// ==== ctrl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder
  import isa_pkg::*, ctrl_pkg::*;
(
  input  logic [OPCODE_W-1:0] opcode,
  output ctrl_word_t          ctrl
);

  opcode_e op;

  assign op = opcode_e'(opcode);

  always_comb
  begin
    ctrl = '0; // nop word, also for float and unused codes
    case (op)
      OP_LD:
      begin
        ctrl.opc_use.has_ry = 1'b1;
        ctrl.wb.rw_r        = 1'b1;
        ctrl.wb.reg_mem     = 1'b1; // load data to rz
        ctrl.mem.mem_r      = 1'b1;
        ctrl.ex.src2_sel    = 1'b1;
        ctrl.ex.alu_op      = ALU_ADD; // base plus offset
        ctrl.ex.pf_or_i     = 1'b1;
        ctrl.ext_sel        = EXT_S15;
      end
      OP_ST:
      begin
        ctrl.opc_use.has_ry = 1'b1;
        ctrl.mem.mem_w      = 1'b1;
        ctrl.ex.src2_sel    = 1'b1;
        ctrl.ex.alu_op      = ALU_ADD;
        ctrl.ex.pf_or_i     = 1'b1;
        ctrl.ext_sel        = EXT_S15;
        ctrl.reg_id_sel     = 1'b1; // store data named by z
      end
      OP_ANDP, OP_ORP, OP_XORP, OP_NOTP,
      OP_RTOP, OP_ISNEG, OP_ISZERO:
      begin
        ctrl.wb.rw_p = 1'b1;
        // value tests read ry, logic ops read predicates only
        ctrl.opc_use.has_ry = (op == OP_RTOP) || (op == OP_ISNEG) || (op == OP_ISZERO);
        case (op)
          OP_ANDP:   ctrl.ex.alu_op = PALU_AND;
          OP_ORP:    ctrl.ex.alu_op = PALU_OR;
          OP_XORP:   ctrl.ex.alu_op = PALU_XOR;
          OP_NOTP:   ctrl.ex.alu_op = PALU_NOT;
          OP_RTOP:   ctrl.ex.alu_op = PALU_RTOP;
          OP_ISNEG:  ctrl.ex.alu_op = PALU_ISNEG;
          OP_ISZERO: ctrl.ex.alu_op = PALU_ISZERO;
          default:   ctrl.ex.alu_op = ALU_NONE;
        endcase
      end
      OP_LDI, OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI,
      OP_MODI, OP_SHLI, OP_SHRI, OP_ANDI, OP_ORI, OP_XORI:
      begin
        ctrl.opc_use.has_ry = (op != OP_LDI);
        ctrl.wb.rw_r        = 1'b1;
        ctrl.ex.src2_sel    = 1'b1;
        ctrl.ex.pf_or_i     = 1'b1;
        ctrl.ext_sel        = (op == OP_LDI) ? EXT_S19 : EXT_S15;
        case (op)
          OP_LDI:  ctrl.ex.alu_op = ALU_PASS;
          OP_ADDI: ctrl.ex.alu_op = ALU_ADD;
          OP_SUBI: ctrl.ex.alu_op = ALU_SUB;
          OP_MULI: ctrl.ex.alu_op = ALU_MUL;
          OP_DIVI: ctrl.ex.alu_op = ALU_DIV;
          OP_MODI: ctrl.ex.alu_op = ALU_MOD;
          OP_SHLI: ctrl.ex.alu_op = ALU_SHL;
          OP_SHRI: ctrl.ex.alu_op = ALU_SHR;
          OP_ANDI: ctrl.ex.alu_op = ALU_AND;
          OP_ORI:  ctrl.ex.alu_op = ALU_OR;
          OP_XORI: ctrl.ex.alu_op = ALU_XOR;
          default: ctrl.ex.alu_op = ALU_NONE;
        endcase
      end
      OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD, OP_SHL,
      OP_SHR, OP_AND, OP_OR, OP_XOR, OP_NEG, OP_NOT:
      begin
        ctrl.opc_use.has_rx = (op != OP_NEG) && (op != OP_NOT); // unary ops read y only
        ctrl.opc_use.has_ry = 1'b1;
        ctrl.wb.rw_r        = 1'b1;
        ctrl.ex.pf_or_i     = 1'b1;
        case (op)
          OP_ADD:  ctrl.ex.alu_op = ALU_ADD;
          OP_SUB:  ctrl.ex.alu_op = ALU_SUB;
          OP_MUL:  ctrl.ex.alu_op = ALU_MUL;
          OP_DIV:  ctrl.ex.alu_op = ALU_DIV;
          OP_MOD:  ctrl.ex.alu_op = ALU_MOD;
          OP_SHL:  ctrl.ex.alu_op = ALU_SHL;
          OP_SHR:  ctrl.ex.alu_op = ALU_SHR;
          OP_AND:  ctrl.ex.alu_op = ALU_AND;
          OP_OR:   ctrl.ex.alu_op = ALU_OR;
          OP_XOR:  ctrl.ex.alu_op = ALU_XOR;
          OP_NEG:  ctrl.ex.alu_op = ALU_NEG;
          OP_NOT:  ctrl.ex.alu_op = ALU_NOT;
          default: ctrl.ex.alu_op = ALU_NONE;
        endcase
      end
      OP_JMPI:
      begin
        ctrl.jmp.reg_or_imm = 1'b1;
        ctrl.jmp.is_jump    = 1'b1;
        ctrl.ext_sel        = EXT_S23;
      end
      OP_JMPR:
      begin
        ctrl.opc_use.has_rx = 1'b1;
        ctrl.jmp.is_jump    = 1'b1;
        ctrl.reg_id_sel     = 1'b1; // target register in z
      end
      OP_JALI:
      begin
        ctrl.wb.rw_r        = 1'b1;
        ctrl.ex.link        = 1'b1;
        ctrl.ex.alu_op      = ALU_LINK;
        ctrl.ex.pf_or_i     = 1'b1;
        ctrl.jmp.reg_or_imm = 1'b1;
        ctrl.jmp.is_jump    = 1'b1;
        ctrl.ext_sel        = EXT_S19;
      end
      OP_JALR:
      begin
        ctrl.opc_use.has_rx = 1'b1;
        ctrl.wb.rw_r        = 1'b1;
        ctrl.ex.link        = 1'b1;
        ctrl.ex.alu_op      = ALU_LINK;
        ctrl.ex.pf_or_i     = 1'b1;
        ctrl.jmp.is_jump    = 1'b1;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter type word_t = logic,
  parameter int  DEPTH  = 4,
  parameter logic [DEPTH*$bits(word_t)-1:0] RESET_IMAGE = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_id,
  input  word_t                    wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_x_id,
  input  logic [$clog2(DEPTH)-1:0] rd_y_id,
  input  logic [$clog2(DEPTH)-1:0] rd_g_id,
  output word_t                    rd_x,
  output word_t                    rd_y,
  output word_t                    rd_g
);

  localparam int W = $bits(word_t);

  word_t regs [DEPTH];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
        regs[i] <= RESET_IMAGE[i*W +: W]; // writes dropped while in reset
    end
    else if (wr_en)
    begin
      regs[wr_id] <= wr_data;
    end
  end

  assign rd_x = regs[rd_x_id];
  assign rd_y = regs[rd_y_id];
  assign rd_g = regs[rd_g_id]; // guard lookup

endmodule

`default_nettype wire

// ==== imm_target_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_target_gen
  import isa_pkg::*, ctrl_pkg::*;
(
  input  ext_sel_e           ext_sel,
  input  logic [IMM_W-1:0]   field,
  input  word_t              pc_n,
  output word_t              imm,
  output word_t              jmp_target
);

  always_comb
  begin
    case (ext_sel)
      EXT_S15:
      begin
        imm = {{(WORD_W-15){field[14]}}, field[14:0]}; // ld, st, alu immediates
      end
      EXT_S23:
      begin
        imm = {{(WORD_W-23){field[22]}}, field[22:0]}; // jmpi
      end
      EXT_S19:
      begin
        imm = {{(WORD_W-19){field[18]}}, field[18:0]}; // ldi, jali
      end
      EXT_NONE:
      begin
        imm = '0;
      end
    endcase
  end

  // pc relative target, consumed only when the jump takes the immediate
  assign jmp_target = pc_n + imm;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import isa_pkg::*, ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  word_t       pc_n,
  input  word_t       inst,
  input  greg_wr_t    greg_wr,
  input  preg_wr_t    preg_wr,
  output stage_ctrl_t ctrl,
  output operands_t   ops
);

  ctrl_word_t cw;
  greg_id_t   x_id;
  greg_id_t   y_id;
  greg_id_t   z_id;
  preg_id_t   pid;
  logic       set_bit;
  word_t      rx;
  word_t      ry;
  logic       px;
  logic       py;
  logic       pguard;
  word_t      imm;
  word_t      jmp_target;

  assign z_id    = inst[Z_MSB:Z_LSB];
  assign y_id    = inst[Y_MSB:Y_LSB];
  assign x_id    = cw.reg_id_sel ? z_id : inst[XALT_MSB:XALT_LSB]; // st, jmpr name x in z
  assign set_bit = inst[SET_BIT];
  assign pid     = inst[PID_MSB:PID_LSB];

  ctrl_decoder u_ctrl_decoder (
    .opcode (inst[OPC_MSB:OPC_LSB]),
    .ctrl   (cw)
  );

  reg_file #(
    .word_t      (word_t),
    .DEPTH       (GREG_COUNT),
    .RESET_IMAGE (GREG_RESET_IMAGE)
  ) gregs (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (greg_wr.en),
    .wr_id   (greg_wr.id),
    .wr_data (greg_wr.value),
    .rd_x_id (x_id),
    .rd_y_id (y_id),
    .rd_g_id ('0),
    .rd_x    (rx),
    .rd_y    (ry),
    .rd_g    ()
  );

  reg_file #(
    .word_t      (logic),
    .DEPTH       (PREG_COUNT),
    .RESET_IMAGE (PREG_RESET_IMAGE)
  ) pregs (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (preg_wr.en),
    .wr_id   (preg_wr.id),
    .wr_data (preg_wr.value),
    .rd_x_id (x_id[$bits(preg_id_t)-1:0]), // low id bits select a predicate
    .rd_y_id (y_id[$bits(preg_id_t)-1:0]),
    .rd_g_id (pid),
    .rd_x    (px),
    .rd_y    (py),
    .rd_g    (pguard)
  );

  imm_target_gen u_imm_target_gen (
    .ext_sel    (cw.ext_sel),
    .field      (inst[IMM_MSB:IMM_LSB]),
    .pc_n       (pc_n),
    .imm        (imm),
    .jmp_target (jmp_target)
  );

  assign ctrl = '{
    opc_use: cw.opc_use,
    wb:      cw.wb,
    mem:     cw.mem,
    ex:      cw.ex,
    jmp:     cw.jmp
  };

  assign ops = '{
    rx:         rx,
    ry:         ry,
    px:         px,
    py:         py,
    x_id:       x_id,
    y_id:       y_id,
    z_id:       z_id,
    imm:        imm,
    jmp_target: jmp_target,
    pval:       set_bit ? pguard : 1'b1 // unguarded instructions always execute
  };

endmodule

`default_nettype wire

// ==== tb_vectors.svh ====
// one row per test: name, inst, expected ctrl, extension width, checks, pc_n,
// rx, ry, px, py, pval, general write, predicate write
task automatic load_vectors();
  push_vector("reset_gregs", reg_inst(OP_ADD, 1, 7, 3),
    ctrl_bits(2'b11, 4'b0100, 2'b00, 1'b0, 1'b0, ALU_ADD, 1'b1, 2'b00), 0,
    CHK_CTRL | CHK_IMM | CHK_RX | CHK_RY, 32'h100, 32'd3, 32'd7);
  push_vector("reset_write_lost", reg_inst(OP_ADD, 0, 0, 5), '0, 0,
    CHK_RX | CHK_RY, 32'h0, 32'd5, 32'd0);
  push_vector("reset_preds_01", reg_inst(OP_ANDP, 0, 1, 0), '0, 0,
    CHK_PX | CHK_PY, '0, '0, '0, 1'b1, 1'b1);
  push_vector("reset_preds_23", reg_inst(OP_ANDP, 0, 3, 2), '0, 0,
    CHK_PX | CHK_PY, '0, '0, '0, 1'b0, 1'b0);
  push_vector("ld", imm_inst(OP_LD, 23'h004010),
    ctrl_bits(2'b01, 4'b0101, 2'b01, 1'b0, 1'b1, ALU_ADD, 1'b1, 2'b00), 15, CI, 32'h1000);
  push_vector("st", imm_inst(OP_ST, 23'h000123),
    ctrl_bits(2'b01, 4'b0000, 2'b10, 1'b0, 1'b1, ALU_ADD, 1'b1, 2'b00), 15, CI | CHK_XZ,
    32'h2000);
  push_vector("st_x_from_z", reg_inst(OP_ST, 6, 0, 2), '0, 15, CHK_RX | CHK_XZ, '0, 32'd6);
  push_vector("andp", reg_inst(OP_ANDP, 0, 1, 2),
    ctrl_bits(2'b00, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_AND, 1'b0, 2'b00), 0, CI);
  push_vector("orp", reg_inst(OP_ORP, 0, 1, 2),
    ctrl_bits(2'b00, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_OR, 1'b0, 2'b00), 0, CI);
  push_vector("xorp", reg_inst(OP_XORP, 0, 1, 2),
    ctrl_bits(2'b00, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_XOR, 1'b0, 2'b00), 0, CI);
  push_vector("notp", reg_inst(OP_NOTP, 0, 1, 2),
    ctrl_bits(2'b00, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_NOT, 1'b0, 2'b00), 0, CI);
  push_vector("rtop", reg_inst(OP_RTOP, 1, 4, 0),
    ctrl_bits(2'b01, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_RTOP, 1'b0, 2'b00), 0, CI);
  push_vector("isneg", reg_inst(OP_ISNEG, 1, 4, 0),
    ctrl_bits(2'b01, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_ISNEG, 1'b0, 2'b00), 0, CI);
  push_vector("iszero", reg_inst(OP_ISZERO, 1, 4, 0),
    ctrl_bits(2'b01, 4'b0010, 2'b00, 1'b0, 1'b0, PALU_ISZERO, 1'b0, 2'b00), 0, CI);
  push_vector("addi", imm_inst(OP_ADDI, 23'h007fff),
    ctrl_bits(2'b01, 4'b0100, 2'b00, 1'b0, 1'b1, ALU_ADD, 1'b1, 2'b00), 15, CI, 32'h40);
  push_vector("add", reg_inst(OP_ADD, 2, 3, 4),
    ctrl_bits(2'b11, 4'b0100, 2'b00, 1'b0, 1'b0, ALU_ADD, 1'b1, 2'b00), 0, CI);
  push_vector("and", reg_inst(OP_AND, 2, 3, 4),
    ctrl_bits(2'b11, 4'b0100, 2'b00, 1'b0, 1'b0, ALU_AND, 1'b1, 2'b00), 0, CI);
  push_vector("neg", reg_inst(OP_NEG, 2, 3, 0),
    ctrl_bits(2'b01, 4'b0100, 2'b00, 1'b0, 1'b0, ALU_NEG, 1'b1, 2'b00), 0, CI);
  push_vector("not", reg_inst(OP_NOT, 2, 3, 0),
    ctrl_bits(2'b01, 4'b0100, 2'b00, 1'b0, 1'b0, ALU_NOT, 1'b1, 2'b00), 0, CI);
  push_vector("jmpi", imm_inst(OP_JMPI, 23'h400000),
    ctrl_bits(2'b00, 4'b0000, 2'b00, 1'b0, 1'b0, ALU_NONE, 1'b0, 2'b11), 23, CI, 32'h500000);
  push_vector("jmpr", reg_inst(OP_JMPR, 11, 0, 4),
    ctrl_bits(2'b10, 4'b0000, 2'b00, 1'b0, 1'b0, ALU_NONE, 1'b0, 2'b01), 0,
    CI | CHK_RX | CHK_XZ, 32'h0, 32'd11);
  push_vector("jali", imm_inst(OP_JALI, 23'h040004),
    ctrl_bits(2'b00, 4'b0100, 2'b00, 1'b1, 1'b0, ALU_LINK, 1'b1, 2'b11), 19, CI, 32'h10);
  push_vector("jalr", reg_inst(OP_JALR, 2, 0, 0),
    ctrl_bits(2'b10, 4'b0100, 2'b00, 1'b1, 1'b0, ALU_LINK, 1'b1, 2'b01), 0, CI);
  push_vector("float_1f", imm_inst(6'h1f, 23'h012345), '0, 0, CI, 32'h80);
  push_vector("float_20", imm_inst(6'h20, 23'h7fffff), '0, 0, CI, 32'h80);
  push_vector("unused_3f", imm_inst(6'h3f, 23'h654321), '0, 0, CI, 32'h80);
  push_vector("rand_addi", imm_inst(OP_ADDI, '0),
    ctrl_bits(2'b01, 4'b0100, 2'b00, 1'b0, 1'b1, ALU_ADD, 1'b1, 2'b00), 15, CI | CHK_RND);
  push_vector("rand_jmpi", imm_inst(OP_JMPI, '0),
    ctrl_bits(2'b00, 4'b0000, 2'b00, 1'b0, 1'b0, ALU_NONE, 1'b0, 2'b11), 23, CI | CHK_RND);
  push_vector("rand_jali", imm_inst(OP_JALI, '0),
    ctrl_bits(2'b00, 4'b0100, 2'b00, 1'b1, 1'b0, ALU_LINK, 1'b1, 2'b11), 19, CI | CHK_RND);
  push_vector("greg_write", reg_inst(OP_ADD, 0, 9, 9), '0, 0, CHK_RX | CHK_RY, '0,
    32'd9, 32'd9, 1'b0, 1'b0, 1'b1, greg_wr_t'{1'b1, 4'd9, 32'hcafef00d});
  push_vector("greg_readback", reg_inst(OP_ADD, 0, 9, 9), '0, 0, CHK_RX | CHK_RY, '0,
    32'hcafef00d, 32'hcafef00d, 1'b0, 1'b0, 1'b1, greg_wr_t'{1'b0, 4'd9, 32'h11111111});
  push_vector("greg_en_low", reg_inst(OP_ADD, 0, 9, 9), '0, 0, CHK_RX | CHK_RY, '0,
    32'hcafef00d, 32'hcafef00d);
  push_vector("preg_write", reg_inst(OP_ANDP, 0, 3, 2), '0, 0, CHK_PX | CHK_PY, '0,
    '0, '0, 1'b0, 1'b0, 1'b1, '0, preg_wr_t'{1'b1, 2'd2, 1'b1});
  push_vector("preg_readback", reg_inst(OP_ANDP, 0, 3, 2), '0, 0, CHK_PX | CHK_PY, '0,
    '0, '0, 1'b1, 1'b0);
  push_vector("guard_p2", with_guard(reg_inst(OP_ANDP, 0, 0, 0), 1'b1, 2), '0, 0,
    CHK_PVAL, '0, '0, '0, 1'b0, 1'b0, 1'b1);
  push_vector("guard_p3", with_guard(reg_inst(OP_ANDP, 0, 0, 0), 1'b1, 3), '0, 0,
    CHK_PVAL, '0, '0, '0, 1'b0, 1'b0, 1'b0);
  push_vector("guard_off", with_guard(reg_inst(OP_ANDP, 0, 0, 0), 1'b0, 3), '0, 0,
    CHK_PVAL, '0, '0, '0, 1'b0, 1'b0, 1'b1);
endtask

// ==== tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode
  import isa_pkg::*, ctrl_pkg::*;
;

  localparam logic [8:0] CHK_CTRL = 9'h001;
  localparam logic [8:0] CHK_IMM  = 9'h002; // imm and jump target
  localparam logic [8:0] CHK_RX   = 9'h004;
  localparam logic [8:0] CHK_RY   = 9'h008;
  localparam logic [8:0] CHK_PX   = 9'h010;
  localparam logic [8:0] CHK_PY   = 9'h020;
  localparam logic [8:0] CHK_PVAL = 9'h040;
  localparam logic [8:0] CHK_RND  = 9'h080; // random field and pc_n
  localparam logic [8:0] CHK_XZ   = 9'h100; // x named by the z field
  localparam logic [8:0] CI       = CHK_CTRL | CHK_IMM;

  typedef struct {
    string       name;
    word_t       inst;
    word_t       pc_n;
    greg_wr_t    gw;
    preg_wr_t    pw;
    stage_ctrl_t ctrl;
    int          ext_w;
    word_t       rx;
    word_t       ry;
    logic        px;
    logic        py;
    logic        pval;
    logic [8:0]  mask;
  } vec_t;

  logic        clk;
  logic        rst;
  word_t       pc_n;
  word_t       inst;
  greg_wr_t    greg_wr;
  preg_wr_t    preg_wr;
  stage_ctrl_t ctrl;
  operands_t   ops;

  vec_t     vecs[$];
  vec_t     cur;
  word_t    exp_imm;
  greg_id_t exp_x_id;
  bit       loaded;
  int       test_errs;
  int       pass_count;
  int       fail_count;
  int       limit_ns;

  decode_stage uut (
    .clk     (clk),
    .rst     (rst),
    .pc_n    (pc_n),
    .inst    (inst),
    .greg_wr (greg_wr),
    .preg_wr (preg_wr),
    .ctrl    (ctrl),
    .ops     (ops)
  );

  initial clk = 1'b0;

  always #10 clk = ~clk;

  function automatic word_t reg_inst(logic [OPCODE_W-1:0] op, int z, int y, int x);
    return {3'b000, op, z[3:0], y[3:0], x[3:0], 11'd0};
  endfunction

  function automatic word_t imm_inst(logic [OPCODE_W-1:0] op, logic [IMM_W-1:0] field);
    return {3'b000, op, field};
  endfunction

  function automatic word_t with_guard(word_t base, logic set, int pid);
    word_t w;
    w = base;
    w[31] = set;
    w[30:29] = pid[1:0];
    return w;
  endfunction

  function automatic stage_ctrl_t ctrl_bits(logic [1:0] use_b, logic [3:0] wb_b,
                                            logic [1:0] mem_b, logic link, logic src2,
                                            alu_op_e alu, logic pf, logic [1:0] jmp_b);
    return {use_b, wb_b, mem_b, link, src2, alu, pf, jmp_b};
  endfunction

  // width 0 means no immediate
  function automatic word_t sign_extend(logic [IMM_W-1:0] field, int width);
    word_t v;
    v = '0;
    if (width > 0)
      for (int b = 0; b < WORD_W; b++)
        v[b] = (b < width) ? field[b] : field[width-1];
    return v;
  endfunction

  task automatic push_vector(string name, word_t i, stage_ctrl_t c, int ext_w,
                             logic [8:0] mask, word_t pc = '0, word_t rx = '0,
                             word_t ry = '0, logic px = 1'b0, logic py = 1'b0,
                             logic pval = 1'b1, greg_wr_t gw = '0, preg_wr_t pw = '0);
    vec_t v;
    v.name  = name;
    v.inst  = i;
    v.pc_n  = pc;
    v.gw    = gw;
    v.pw    = pw;
    v.ctrl  = c;
    v.ext_w = ext_w;
    v.rx    = rx;
    v.ry    = ry;
    v.px    = px;
    v.py    = py;
    v.pval  = pval;
    v.mask  = mask;
    vecs.push_back(v);
  endtask

  `include "tb_vectors.svh"

  task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error %s %s: expected %h actual %h", cur.name, what, expected, actual);
      test_errs++;
    end
  endtask

  initial
  begin
    rst     = 1'b1;
    pc_n    = '0;
    inst    = '0;
    greg_wr = '0;
    preg_wr = '0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(64));
    load_vectors();
    loaded = 1'b1;
    @(posedge clk);
    #1;
    greg_wr = greg_wr_t'{1'b1, 4'd5, 32'hdeadbeef}; // must not land while in reset
    repeat (3) @(posedge clk);
    #1;
    rst     = 1'b0;
    greg_wr = '0;
    foreach (vecs[i])
    begin
      @(posedge clk);
      #1;
      cur = vecs[i];
      if ((cur.mask & CHK_RND) != 0)
      begin
        cur.inst[IMM_MSB:IMM_LSB] = IMM_W'($urandom);
        cur.pc_n = $urandom;
      end
      inst    = cur.inst;
      pc_n    = cur.pc_n;
      greg_wr = cur.gw;
      preg_wr = cur.pw;
      @(negedge clk); // outputs settled, write not yet taken
      test_errs = 0;
      exp_imm = sign_extend(cur.inst[IMM_MSB:IMM_LSB], cur.ext_w);
      exp_x_id = ((cur.mask & CHK_XZ) != 0) ? cur.inst[Z_MSB:Z_LSB]
                                             : cur.inst[XALT_MSB:XALT_LSB];
      if ((cur.mask & CHK_CTRL) != 0)
        check("ctrl", 32'(cur.ctrl), 32'(ctrl));
      if ((cur.mask & CHK_IMM) != 0)
      begin
        check("imm", exp_imm, ops.imm);
        check("jmp_target", cur.pc_n + exp_imm, ops.jmp_target);
      end
      if ((cur.mask & CHK_RX) != 0)
        check("rx", cur.rx, ops.rx);
      if ((cur.mask & CHK_RY) != 0)
        check("ry", cur.ry, ops.ry);
      if ((cur.mask & CHK_PX) != 0)
        check("px", 32'(cur.px), 32'(ops.px));
      if ((cur.mask & CHK_PY) != 0)
        check("py", 32'(cur.py), 32'(ops.py));
      if ((cur.mask & CHK_PVAL) != 0)
        check("pval", 32'(cur.pval), 32'(ops.pval));
      check("x_id", 32'(exp_x_id), 32'(ops.x_id));
      check("y_id", 32'(cur.inst[Y_MSB:Y_LSB]), 32'(ops.y_id));
      check("z_id", 32'(cur.inst[Z_MSB:Z_LSB]), 32'(ops.z_id));
      if (test_errs == 0)
      begin
        pass_count++;
        $display("%-18s ok", cur.name);
      end
      else
      begin
        fail_count++;
        $display("%-18s %0d mismatches", cur.name, test_errs);
      end
    end
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // bound on the whole run, reset included
  initial
  begin
    wait (loaded);
    limit_ns = (vecs.size() + 10) * 40;
    #(limit_ns);
    $display("Timeout: the test table did not finish within %0d ns", limit_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
ctrl_decoder.sv
reg_file.sv
imm_target_gen.sv
decode_stage.sv
tb_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the printed result, the binary output is shown as it is
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
